// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the chroma mode search testbench with Verilator

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f uv_mode_search.f \
    --top-module tb_uv_mode_search \
    -Mdir obj_dir \
    -o sim_uv_mode_search

./obj_dir/sim_uv_mode_search | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: source/uv_mode_search.sv
// Chroma intra mode search, top level
// Start capture, mode issue sequencer, best-candidate store,
// done strobe and U/V output split

`default_nettype none
`timescale 1ns/1ps

module uv_mode_search (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [127:0]                src_u,
    input  logic [127:0]                src_v,
    input  logic [31:0]                 top_u,
    input  logic [31:0]                 top_v,
    input  logic [31:0]                 left_u,
    input  logic [31:0]                 left_v,
    input  logic [7:0]                  top_left_u,
    input  logic [7:0]                  top_left_v,
    input  logic [uv_pkg::qshift_w-1:0] qshift,
    input  logic [uv_pkg::lambda_w-1:0] lambda,
    output logic                        done,
    output logic [uv_pkg::mode_w-1:0]   best_mode,
    output logic [uv_pkg::score_w-1:0]  best_score,
    output logic [127:0]                recon_u,
    output logic [127:0]                recon_v,
    output logic [143:0]                levels_u,
    output logic [143:0]                levels_v,
    output logic [31:0]                 nz
);

    logic                          accept;
    logic                          busy;
    logic                          issue_active;
    logic [uv_pkg::mode_w-1:0]     issue_cnt;
    logic [uv_pkg::mode_w-1:0]     res_cnt;
    logic [255:0]                  src_r;
    logic [uv_pkg::qshift_w-1:0]   qshift_r;
    logic [uv_pkg::lambda_w-1:0]   lambda_r;

    logic [255:0]                  pred_dc;
    logic [255:0]                  pred_tm;
    logic [255:0]                  pred_ve;
    logic [255:0]                  pred_he;
    logic                          cand_valid;
    logic [uv_pkg::mode_w-1:0]     cand_mode;
    logic [255:0]                  cand_pred;

    logic                          recon_valid;
    logic [uv_pkg::mode_w-1:0]     recon_mode;
    logic [255:0]                  rec_recon;
    logic [287:0]                  rec_levels;
    logic [31:0]                   rec_nz;
    logic [15:0]                   rec_rate;

    logic                          score_valid;
    logic [uv_pkg::mode_w-1:0]     score_mode;
    logic [uv_pkg::score_w-1:0]    score;
    logic [255:0]                  score_recon;
    logic [287:0]                  score_levels;
    logic [31:0]                   score_nz;

    logic                          take;
    logic                          last;
    logic [uv_pkg::score_w-1:0]    best_score_r;
    logic [uv_pkg::mode_w-1:0]     best_mode_r;
    logic [255:0]                  best_recon_r;
    logic [287:0]                  best_levels_r;
    logic [31:0]                   best_nz_r;
    logic [uv_pkg::score_w-1:0]    sel_score;
    logic [uv_pkg::mode_w-1:0]     sel_mode;
    logic [255:0]                  sel_recon;
    logic [287:0]                  sel_levels;
    logic [31:0]                   sel_nz;
    logic [255:0]                  out_recon;
    logic [287:0]                  out_levels;

    // ------------------------------
    // Start capture and sequencer
    // ------------------------------
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (accept) begin
            src_r    <= {src_v, src_u};
            qshift_r <= qshift;
            lambda_r <= lambda;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            issue_active <= 1'b0;
            issue_cnt    <= '0;
            cand_valid   <= 1'b0;
            cand_mode    <= '0;
            res_cnt      <= '0;
        end else begin
            cand_valid <= issue_active;
            cand_mode  <= issue_cnt;
            if (accept) begin
                busy         <= 1'b1;
                issue_active <= 1'b1;
                issue_cnt    <= uv_pkg::mode_he;
            end else if (issue_active) begin
                issue_cnt <= issue_cnt - 1'b1;
                if (issue_cnt == uv_pkg::mode_dc)
                    issue_active <= 1'b0;
            end
            if (score_valid)
                res_cnt <= res_cnt + 1'b1;
            if (last)
                busy <= 1'b0;
        end
    end

    always_comb begin
        case (cand_mode)
            uv_pkg::mode_dc: cand_pred = pred_dc;
            uv_pkg::mode_tm: cand_pred = pred_tm;
            uv_pkg::mode_ve: cand_pred = pred_ve;
            default:         cand_pred = pred_he;
        endcase
    end

    uv_pred_gen u_pred_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_load  (accept),
        .top_u      (top_u),
        .top_v      (top_v),
        .left_u     (left_u),
        .left_v     (left_v),
        .top_left_u (top_left_u),
        .top_left_v (top_left_v),
        .pred_dc    (pred_dc),
        .pred_tm    (pred_tm),
        .pred_ve    (pred_ve),
        .pred_he    (pred_he)
    );

    uv_quant_recon u_quant_recon (
        .clk         (clk),
        .rst_n       (rst_n),
        .cand_valid  (cand_valid),
        .cand_mode   (cand_mode),
        .src         (src_r),
        .pred        (cand_pred),
        .qshift      (qshift_r),
        .recon_valid (recon_valid),
        .recon_mode  (recon_mode),
        .recon       (rec_recon),
        .levels      (rec_levels),
        .nz          (rec_nz),
        .rate        (rec_rate)
    );

    uv_rd_score u_rd_score (
        .clk          (clk),
        .rst_n        (rst_n),
        .recon_valid  (recon_valid),
        .recon_mode   (recon_mode),
        .src          (src_r),
        .recon        (rec_recon),
        .levels       (rec_levels),
        .nz           (rec_nz),
        .rate         (rec_rate),
        .lambda       (lambda_r),
        .score_valid  (score_valid),
        .score_mode   (score_mode),
        .score        (score),
        .score_recon  (score_recon),
        .score_levels (score_levels),
        .score_nz     (score_nz)
    );

    // ------------------------------
    // Best-candidate store
    // ------------------------------
    // Modes arrive 3 down to 0, so <= hands ties to the lower code
    assign take = score_valid && (res_cnt == '0 || score <= best_score_r);
    assign last = score_valid && (res_cnt == '1);

    assign sel_score  = take ? score        : best_score_r;
    assign sel_mode   = take ? score_mode   : best_mode_r;
    assign sel_recon  = take ? score_recon  : best_recon_r;
    assign sel_levels = take ? score_levels : best_levels_r;
    assign sel_nz     = take ? score_nz     : best_nz_r;

    always_ff @(posedge clk) begin
        if (score_valid) begin
            best_score_r  <= sel_score;
            best_mode_r   <= sel_mode;
            best_recon_r  <= sel_recon;
            best_levels_r <= sel_levels;
            best_nz_r     <= sel_nz;
        end
    end

    // Outputs change only together with done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done       <= 1'b0;
            best_mode  <= '0;
            best_score <= '0;
            out_recon  <= '0;
            out_levels <= '0;
            nz         <= '0;
        end else begin
            done <= last;
            if (last) begin
                best_mode  <= sel_mode;
                best_score <= sel_score;
                out_recon  <= sel_recon;
                out_levels <= sel_levels;
                nz         <= sel_nz;
            end
        end
    end

    assign recon_u  = out_recon[127:0];
    assign recon_v  = out_recon[255:128];
    assign levels_u = out_levels[143:0];
    assign levels_v = out_levels[287:144];

endmodule

`default_nettype wire

// File: source/uv_pkg.sv
// Shared definitions for the chroma intra mode search
// Pixel, level, mode and score widths, chroma mode codes,
// mode signalling costs and datapath latencies

`default_nettype none

package uv_pkg;

    // ------------------------------
    // Block geometry and widths
    // ------------------------------
    localparam int num_pix  = 16;
    localparam int pix_w    = 8;
    localparam int level_w  = 9;
    localparam int mode_w   = 2;
    localparam int qshift_w = 3;
    localparam int lambda_w = 16;
    localparam int score_w  = 48;

    // Chroma predictor codes
    localparam logic [mode_w-1:0] mode_dc = 2'd0;
    localparam logic [mode_w-1:0] mode_tm = 2'd1;
    localparam logic [mode_w-1:0] mode_ve = 2'd2;
    localparam logic [mode_w-1:0] mode_he = 2'd3;

    // Cost of signalling each mode, indexed by mode code
    localparam logic [3:0][15:0] fixed_cost = {16'd642, 16'd439, 16'd984, 16'd302};

    // ------------------------------
    // Pipeline latencies in cycles
    // ------------------------------
    localparam int recon_lat = 1;
    localparam int score_lat = 2;

endpackage

`default_nettype wire

// File: source/uv_pred_gen.sv
// Chroma predictor generator
// Builds DC, TrueMotion, vertical and horizontal predictions
// for the U and V 4x4 blocks and holds them until the next load

`default_nettype none
`timescale 1ns/1ps

module uv_pred_gen (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         pred_load,
    input  logic [31:0]  top_u,
    input  logic [31:0]  top_v,
    input  logic [31:0]  left_u,
    input  logic [31:0]  left_v,
    input  logic [7:0]   top_left_u,
    input  logic [7:0]   top_left_v,
    output logic [255:0] pred_dc,
    output logic [255:0] pred_tm,
    output logic [255:0] pred_ve,
    output logic [255:0] pred_he
);

    logic [1:0][31:0] top_p;
    logic [1:0][31:0] left_p;
    logic [1:0][7:0]  corner_p;
    logic [255:0]     dc_c;
    logic [255:0]     tm_c;
    logic [255:0]     ve_c;
    logic [255:0]     he_c;

    // Plane 1 is V in the upper half of every prediction
    assign top_p    = {top_v, top_u};
    assign left_p   = {left_v, left_u};
    assign corner_p = {top_left_v, top_left_u};

    always_comb begin
        logic [10:0]        dc_sum;
        logic signed [10:0] tm;
        logic [7:0]         t;
        logic [7:0]         l;
        int                 pos;
        dc_c = '0;
        tm_c = '0;
        ve_c = '0;
        he_c = '0;
        for (int p = 0; p < 2; p++) begin
            // Rounded average of four top and four left pixels
            dc_sum = 11'd4;
            for (int k = 0; k < 4; k++) begin
                dc_sum = dc_sum + 11'(top_p[p][8*k +: 8]) + 11'(left_p[p][8*k +: 8]);
            end
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    pos = (p * uv_pkg::num_pix + r * 4 + c) * uv_pkg::pix_w;
                    t   = top_p[p][8*c +: 8];
                    l   = left_p[p][8*r +: 8];
                    tm  = $signed({3'b000, l}) + $signed({3'b000, t})
                        - $signed({3'b000, corner_p[p]});
                    dc_c[pos +: 8] = dc_sum[10:3];
                    ve_c[pos +: 8] = t;
                    he_c[pos +: 8] = l;
                    if (tm < 0)
                        tm_c[pos +: 8] = 8'd0;
                    else if (tm > 11'sd255)
                        tm_c[pos +: 8] = 8'd255;
                    else
                        tm_c[pos +: 8] = tm[7:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_dc <= '0;
            pred_tm <= '0;
            pred_ve <= '0;
            pred_he <= '0;
        end else if (pred_load) begin
            pred_dc <= dc_c;
            pred_tm <= tm_c;
            pred_ve <= ve_c;
            pred_he <= he_c;
        end
    end

endmodule

`default_nettype wire

// File: source/uv_quant_recon.sv
// Quantiser and reconstruction for one candidate mode
// Rounding-shift quantisation of the U and V residuals, clipped
// reconstruction, non-zero mask and summed level magnitude

`default_nettype none
`timescale 1ns/1ps

module uv_quant_recon (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cand_valid,
    input  logic [uv_pkg::mode_w-1:0]   cand_mode,
    input  logic [255:0]                src,
    input  logic [255:0]                pred,
    input  logic [uv_pkg::qshift_w-1:0] qshift,
    output logic                        recon_valid,
    output logic [uv_pkg::mode_w-1:0]   recon_mode,
    output logic [255:0]                recon,
    output logic [287:0]                levels,
    output logic [31:0]                 nz,
    output logic [15:0]                 rate
);

    logic [255:0] recon_c;
    logic [287:0] levels_c;
    logic [31:0]  nz_c;
    logic [15:0]  rate_c;

    logic [uv_pkg::recon_lat-1:0] vld_sr;
    // Mode tag, recon, levels, nz and rate
    logic [593:0]                 out_sr [uv_pkg::recon_lat];

    always_comb begin
        logic signed [9:0]  resid;
        logic [8:0]         mag;
        logic [8:0]         half;
        logic [8:0]         qlev;
        logic signed [8:0]  lvl;
        logic signed [17:0] rec;
        int                 pos;
        recon_c  = '0;
        levels_c = '0;
        nz_c     = '0;
        rate_c   = '0;
        // Half step is zero when there is no shift
        half = 9'((1 << qshift) >> 1);
        for (int i = 0; i < 2 * uv_pkg::num_pix; i++) begin
            pos   = i * uv_pkg::pix_w;
            resid = $signed({2'b00, src[pos +: 8]}) - $signed({2'b00, pred[pos +: 8]});
            mag   = resid[9] ? 9'(-resid) : 9'(resid);
            qlev  = (mag + half) >> qshift;
            lvl   = resid[9] ? -$signed(qlev) : $signed(qlev);
            rec   = $signed({10'd0, pred[pos +: 8]}) + (18'(lvl) <<< qshift);
            levels_c[i*uv_pkg::level_w +: uv_pkg::level_w] = lvl;
            nz_c[i] = (qlev != '0);
            rate_c  = rate_c + 16'(qlev);
            if (rec < 0)
                recon_c[pos +: 8] = 8'd0;
            else if (rec > 18'sd255)
                recon_c[pos +: 8] = 8'd255;
            else
                recon_c[pos +: 8] = rec[7:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= cand_valid;
            for (int i = 1; i < uv_pkg::recon_lat; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        out_sr[0] <= {cand_mode, recon_c, levels_c, nz_c, rate_c};
        for (int i = 1; i < uv_pkg::recon_lat; i++) begin
            out_sr[i] <= out_sr[i-1];
        end
    end

    assign recon_valid = vld_sr[uv_pkg::recon_lat-1];
    assign {recon_mode, recon, levels, nz, rate} = out_sr[uv_pkg::recon_lat-1];

endmodule

`default_nettype wire

// File: source/uv_rd_score.sv
// Rate-distortion scoring pipeline
// Stage 1 sums squared error and builds the rate term,
// stage 2 weights the rate by lambda and adds the distortion

`default_nettype none
`timescale 1ns/1ps

module uv_rd_score (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        recon_valid,
    input  logic [uv_pkg::mode_w-1:0]   recon_mode,
    input  logic [255:0]                src,
    input  logic [255:0]                recon,
    input  logic [287:0]                levels,
    input  logic [31:0]                 nz,
    input  logic [15:0]                 rate,
    input  logic [uv_pkg::lambda_w-1:0] lambda,
    output logic                        score_valid,
    output logic [uv_pkg::mode_w-1:0]   score_mode,
    output logic [uv_pkg::score_w-1:0]  score,
    output logic [255:0]                score_recon,
    output logic [287:0]                score_levels,
    output logic [31:0]                 score_nz
);

    logic [20:0] sse_c;
    logic [26:0] rterm_c;
    logic [20:0] s1_sse;
    logic [26:0] s1_rterm;

    logic [uv_pkg::score_lat-1:0] vld_sr;
    // Candidate data riding along with its score
    logic [577:0]                 carry_sr [uv_pkg::score_lat];

    // ------------------------------
    // Stage 1
    // ------------------------------
    always_comb begin
        logic signed [8:0]  diff;
        logic signed [17:0] sq;
        sse_c = '0;
        for (int i = 0; i < 2 * uv_pkg::num_pix; i++) begin
            diff  = $signed({1'b0, src[8*i +: 8]}) - $signed({1'b0, recon[8*i +: 8]});
            sq    = diff * diff;
            sse_c = sse_c + 21'($unsigned(sq));
        end
    end

    assign rterm_c = (27'(rate) << 10) + 27'(uv_pkg::fixed_cost[recon_mode]);

    // ------------------------------
    // Stage 2 and carry
    // ------------------------------
    always_ff @(posedge clk) begin
        s1_sse   <= sse_c;
        s1_rterm <= rterm_c;
        score    <= 48'(s1_rterm) * 48'(lambda) + (48'(s1_sse) << 8);
        carry_sr[0] <= {recon_mode, recon, levels, nz};
        for (int i = 1; i < uv_pkg::score_lat; i++) begin
            carry_sr[i] <= carry_sr[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= recon_valid;
            for (int i = 1; i < uv_pkg::score_lat; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    assign score_valid = vld_sr[uv_pkg::score_lat-1];
    assign {score_mode, score_recon, score_levels, score_nz} = carry_sr[uv_pkg::score_lat-1];

endmodule

`default_nettype wire

// File: uv_mode_search.f
source/uv_pkg.sv
source/uv_pred_gen.sv
source/uv_quant_recon.sv
source/uv_rd_score.sv
source/uv_mode_search.sv
verification/uv_mode_search_asserts.sv
verification/tb_uv_mode_search.sv

// File: verification/tb_uv_mode_search.sv
// Testbench for the chroma intra mode search
// Clock and reset, reference model of the four chroma predictors,
// directed tests for reset, vertical match, ties, random blocks
// and start timing, watchdog and closing result line

`default_nettype none
`timescale 1ns/1ps

module tb_uv_mode_search;

    localparam int clk_period      = 8;
    localparam int num_searches    = 25;
    localparam int watchdog_cycles = num_searches * 20 + 100;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         start;
    logic [127:0] src_u;
    logic [127:0] src_v;
    logic [31:0]  top_u;
    logic [31:0]  top_v;
    logic [31:0]  left_u;
    logic [31:0]  left_v;
    logic [7:0]   top_left_u;
    logic [7:0]   top_left_v;
    logic [2:0]   qshift;
    logic [15:0]  lambda;
    logic         done;
    logic [1:0]   best_mode;
    logic [47:0]  best_score;
    logic [127:0] recon_u;
    logic [127:0] recon_v;
    logic [143:0] levels_u;
    logic [143:0] levels_v;
    logic [31:0]  nz;

    // Expected results from the reference model
    logic [1:0]   exp_mode;
    logic [47:0]  exp_score;
    logic [255:0] exp_recon;
    logic [287:0] exp_levels;
    logic [31:0]  exp_nz;
    logic [31:0]  rng;
    int           errors;
    int           checks;

    uv_mode_search u_uv_mode_search (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .src_u      (src_u),
        .src_v      (src_v),
        .top_u      (top_u),
        .top_v      (top_v),
        .left_u     (left_u),
        .left_v     (left_v),
        .top_left_u (top_left_u),
        .top_left_v (top_left_v),
        .qshift     (qshift),
        .lambda     (lambda),
        .done       (done),
        .best_mode  (best_mode),
        .best_score (best_score),
        .recon_u    (recon_u),
        .recon_v    (recon_v),
        .levels_u   (levels_u),
        .levels_v   (levels_v),
        .nz         (nz)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int clip_pixel(input int v);
        if (v < 0)
            return 0;
        else if (v > 255)
            return 255;
        return v;
    endfunction

    // Signalling cost of each chroma mode
    function automatic int mode_rate_cost(input int m);
        case (m)
            0:       return 302;
            1:       return 984;
            2:       return 439;
            default: return 642;
        endcase
    endfunction

    task automatic report_mismatch(input string tag, input string sig,
                                   input logic [287:0] expv, input logic [287:0] gotv);
        errors++;
        $display("Fail time=%0t %s %s expected %0h got %0h", $time, tag, sig, expv, gotv);
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int k = 0; k < 4; k++) begin
            src_u[32*k +: 32] = xorshift();
            src_v[32*k +: 32] = xorshift();
        end
        top_u      = xorshift();
        top_v      = xorshift();
        left_u     = xorshift();
        left_v     = xorshift();
        rnd        = xorshift();
        top_left_u = rnd[7:0];
        top_left_v = rnd[15:8];
        lambda     = rnd[31:16];
    endtask

    // Tries all four modes on the current inputs and lets the lower code win a tie
    task automatic model_search();
        logic [255:0] src_all;
        logic [63:0]  tp;
        logic [63:0]  lp;
        logic [15:0]  tlp;
        logic [255:0] rc;
        logic [287:0] lv_all;
        logic [31:0]  mask;
        int           dc [2];
        int           qs;
        int           half;
        int           i;
        int           s;
        int           t;
        int           l;
        int           pr;
        int           res;
        int           mag;
        int           q;
        int           lv;
        int           rec;
        int           rate;
        int           sse;
        longint       sc;
        src_all = {src_v, src_u};
        tp      = {top_v, top_u};
        lp      = {left_v, left_u};
        tlp     = {top_left_v, top_left_u};
        qs      = int'(qshift);
        half    = (1 << qs) / 2;
        for (int p = 0; p < 2; p++) begin
            dc[p] = 4;
            for (int k = 0; k < 4; k++) begin
                dc[p] += int'(tp[32*p + 8*k +: 8]) + int'(lp[32*p + 8*k +: 8]);
            end
            dc[p] = dc[p] / 8;
        end
        for (int m = 0; m < 4; m++) begin
            rate   = 0;
            sse    = 0;
            rc     = '0;
            lv_all = '0;
            mask   = '0;
            for (int p = 0; p < 2; p++) begin
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        i = p * 16 + r * 4 + c;
                        s = int'(src_all[8*i +: 8]);
                        t = int'(tp[32*p + 8*c +: 8]);
                        l = int'(lp[32*p + 8*r +: 8]);
                        case (m)
                            0:       pr = dc[p];
                            1:       pr = clip_pixel(l + t - int'(tlp[8*p +: 8]));
                            2:       pr = t;
                            default: pr = l;
                        endcase
                        res = s - pr;
                        mag = (res < 0) ? -res : res;
                        q   = (mag + half) >> qs;
                        lv  = (res < 0) ? -q : q;
                        rec = clip_pixel(pr + lv * (1 << qs));
                        rate += q;
                        sse  += (s - rec) * (s - rec);
                        rc[8*i +: 8]     = rec[7:0];
                        lv_all[9*i +: 9] = lv[8:0];
                        mask[i]          = (q != 0);
                    end
                end
            end
            sc = (longint'(rate) * 1024 + longint'(mode_rate_cost(m))) * longint'(lambda)
               + 256 * longint'(sse);
            if (m == 0 || sc < longint'(exp_score)) begin
                exp_mode   = 2'(m);
                exp_score  = sc[47:0];
                exp_recon  = rc;
                exp_levels = lv_all;
                exp_nz     = mask;
            end
        end
    endtask

    task automatic check_outputs(input string tag);
        checks++;
        if (best_mode !== exp_mode)
            report_mismatch(tag, "best_mode", exp_mode, best_mode);
        if (best_score !== exp_score)
            report_mismatch(tag, "best_score", exp_score, best_score);
        if (recon_u !== exp_recon[127:0])
            report_mismatch(tag, "recon_u", exp_recon[127:0], recon_u);
        if (recon_v !== exp_recon[255:128])
            report_mismatch(tag, "recon_v", exp_recon[255:128], recon_v);
        if (levels_u !== exp_levels[143:0])
            report_mismatch(tag, "levels_u", exp_levels[143:0], levels_u);
        if (levels_v !== exp_levels[287:144])
            report_mismatch(tag, "levels_v", exp_levels[287:144], levels_v);
        if (nz !== exp_nz)
            report_mismatch(tag, "nz", exp_nz, nz);
    endtask

    // Called on a falling edge so that start is sampled on the next rising edge
    task automatic launch();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input string tag);
        int lat;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (done !== 1'b1 && lat < 40);
        if (done !== 1'b1) begin
            errors++;
            $display("Error time=%0t %s: no done within %0d cycles of start", $time, tag, lat);
        end else if (lat != 8) begin
            report_mismatch(tag, "done latency", 8, lat);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic check_reset_state();
        exp_mode   = '0;
        exp_score  = '0;
        exp_recon  = '0;
        exp_levels = '0;
        exp_nz     = '0;
        repeat (3) begin
            @(negedge clk);
            if (done !== 1'b0)
                report_mismatch("reset", "done", 0, done);
            check_outputs("reset");
        end
    endtask

    task automatic vertical_match();
        @(negedge clk);
        top_u      = {8'd200, 8'd20, 8'd180, 8'd40};
        top_v      = {8'd10, 8'd250, 8'd90, 8'd130};
        left_u     = {8'd60, 8'd120, 8'd5, 8'd230};
        left_v     = {8'd77, 8'd33, 8'd211, 8'd150};
        top_left_u = 8'd99;
        top_left_v = 8'd17;
        src_u      = {4{top_u}};
        src_v      = {4{top_v}};
        qshift     = 3'd0;
        lambda     = 16'd100;
        // Every other mode leaves a non-zero level
        exp_mode   = 2'd2;
        exp_score  = 48'd439 * 48'(lambda);
        exp_recon  = {src_v, src_u};
        exp_levels = '0;
        exp_nz     = '0;
        launch();
        wait_done("vertical");
        check_outputs("vertical");
    endtask

    task automatic tie_rule();
        @(negedge clk);
        src_u      = {16{8'd77}};
        src_v      = {16{8'd77}};
        top_u      = {4{8'd77}};
        top_v      = {4{8'd77}};
        left_u     = {4{8'd77}};
        left_v     = {4{8'd77}};
        top_left_u = 8'd77;
        top_left_v = 8'd77;
        qshift     = 3'd3;
        lambda     = 16'd0;
        exp_mode   = 2'd0;
        exp_score  = '0;
        exp_recon  = {src_v, src_u};
        exp_levels = '0;
        exp_nz     = '0;
        launch();
        wait_done("tie");
        check_outputs("tie");
    endtask

    task automatic random_blocks();
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            fill_random();
            qshift = 3'(k % 8);
            model_search();
            launch();
            wait_done("random");
            check_outputs("random");
        end
    endtask

    task automatic timing_and_busy();
        int dones;
        int first;
        @(negedge clk);
        fill_random();
        qshift = 3'd2;
        model_search();
        launch();
        dones = 0;
        first = 0;
        // A second start three cycles in must not disturb the search
        for (int n = 1; n <= 16; n++) begin
            @(negedge clk);
            if (done === 1'b1) begin
                dones++;
                if (first == 0) begin
                    first = n;
                    check_outputs("busy start");
                end
            end
            if (n == 3) begin
                src_u  = ~src_u;
                lambda = lambda ^ 16'h5a5a;
                start  = 1'b1;
            end else begin
                start = 1'b0;
            end
        end
        if (dones != 1)
            report_mismatch("busy start", "done count", 1, dones);
        if (first != 8)
            report_mismatch("busy start", "done latency", 8, first);
        // Back to back with the next start right after done
        @(negedge clk);
        fill_random();
        qshift = 3'd5;
        model_search();
        launch();
        wait_done("back to back first");
        check_outputs("back to back first");
        fill_random();
        qshift = 3'd1;
        model_search();
        launch();
        wait_done("back to back second");
        check_outputs("back to back second");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        rng        = 32'd40;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        start      = 1'b0;
        src_u      = '0;
        src_v      = '0;
        top_u      = '0;
        top_v      = '0;
        left_u     = '0;
        left_v     = '0;
        top_left_u = '0;
        top_left_v = '0;
        qshift     = '0;
        lambda     = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        vertical_match();
        tie_rule();
        random_blocks();
        timing_and_busy();
        @(negedge clk);
        $display("Summary: %0d output checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired, tests did not finish within %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/uv_mode_search_asserts.sv
// Protocol assertions for the chroma mode search top level
// Done pulse width and latency, start while busy, output hold

`default_nettype none
`timescale 1ns/1ps

module uv_mode_search_asserts (
    input logic         clk,
    input logic         rst_n,
    input logic         start,
    input logic         busy,
    input logic         done,
    input logic [274:0] capt,
    input logic [625:0] outs
);

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done) else $error("done held for more than one cycle");

    // Done register rises on the eighth edge after the accepting edge
    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |-> ##9 done) else $error("done not 8 cycles after start");

    a_busy_ignore: assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy) |=> $stable(capt)) else $error("start taken while busy");

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !done |-> $stable(outs)) else $error("outputs changed without done");

endmodule

bind uv_mode_search uv_mode_search_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done),
    .capt  ({src_r, qshift_r, lambda_r}),
    .outs  ({best_mode, best_score, recon_u, recon_v, levels_u, levels_v, nz})
);

`default_nettype wire
